// ==== Makefile ====
SIM   := verilator
FLAGS := --binary --timing --assert -Wno-fatal
TOP   := adxl_tb
FLIST := vlog.f
LOG   := sim.log

SRCS := $(wildcard src/*.sv src/*.svh dv/*.sv)
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== dv/adxl_props.sv ====
/* concurrent checks on the ADXL355 SPI pins, buffer strobes and tag request
   bound into the frame sequencer */
`timescale 1ns/1ps
`include "adxl_defs.svh"

module adxl_props (
  input logic                 clk,
  input logic                 rst_n,
  input logic                 clk_en,
  input logic                 direct_en,
  input logic                 adxl_sclk,
  input logic                 adxl_mosi,
  input logic                 adxl_csn,
  input logic                 wr16,
  input logic                 frame_start,
  input logic                 tag_req,
  input adxl_pkg::byte_t      cmd_q,
  input adxl_pkg::len_t       len_q,
  input adxl_pkg::seq_state_t state
);

  logic            sclk_d;
  logic            csn_d;
  logic            wrote;    // buffer written since csn fell
  logic [7:0]      rises;    // sclk rising edges this frame
  adxl_pkg::byte_t mosi_cap; // mosi bits taken at each sclk rise
  int              fails = 0; // assertion failures so far

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      sclk_d   <= 1'b0;
      csn_d    <= 1'b1;
      wrote    <= 1'b0;
      rises    <= '0;
      mosi_cap <= '0;
    end
    else
    begin
      sclk_d <= adxl_sclk;
      csn_d  <= adxl_csn;
      if (!adxl_csn && csn_d)
        rises <= '0; // new frame
      else if (adxl_sclk && !sclk_d && !direct_en)
      begin
        rises    <= rises + 8'd1;
        mosi_cap <= {mosi_cap[6:0], adxl_mosi};
      end
      if (!adxl_csn && csn_d)
        wrote <= 1'b0;
      else if (wr16)
        wrote <= 1'b1;
    end
  end

  a_sclk_low_csn_high: assert property (@(posedge clk) disable iff (!rst_n || direct_en)
    adxl_csn |-> !adxl_sclk)
    else
    begin
      $error("sclk high while csn is high");
      fails++;
    end

  a_csn_high_idle: assert property (@(posedge clk) disable iff (!rst_n || direct_en)
    (state == adxl_pkg::SEQ_IDLE) |-> adxl_csn)
    else
    begin
      $error("csn low while sequencer idle");
      fails++;
    end

  a_cmd_on_mosi: assert property (@(posedge clk) disable iff (!rst_n || direct_en)
    (adxl_sclk && !sclk_d && rises == 8'd7) |-> ({mosi_cap[6:0], adxl_mosi} == cmd_q))
    else
    begin
      $error("command byte on mosi differs from cmd");
      fails++;
    end

  a_sclk_count: assert property (@(posedge clk) disable iff (!rst_n || direct_en)
    $rose(adxl_csn) |-> (rises == {1'b0, len_q, 3'b000}))
    else
    begin
      $error("sclk pulse count differs from len*8");
      fails++;
    end

  a_no_write_direct: assert property (@(posedge clk) disable iff (!rst_n)
    direct_en |-> !wr16)
    else
    begin
      $error("buffer write during direct mode");
      fails++;
    end

  a_grant_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
    $changed(direct_en) |-> ($past(state) == adxl_pkg::SEQ_IDLE && $past(clk_en)))
    else
    begin
      $error("direct grant moved outside an idle tick");
      fails++;
    end

  // first write after csn falls carries frame_start, later ones do not
  a_start_first_write: assert property (@(posedge clk) disable iff (!rst_n)
    wr16 |-> (frame_start == !wrote))
    else
    begin
      $error("frame_start not on the first write of a frame");
      fails++;
    end

  // csn falls on the first clk_en tick after the start edge
  a_csn_after_req: assert property (@(posedge clk) disable iff (!rst_n || direct_en)
    tag_req |-> ##(`ADXL_CLKDIV) $fell(adxl_csn))
    else
    begin
      $error("csn did not fall on the first tick after frame start");
      fails++;
    end

endmodule

bind adxl_spi_reader adxl_props u_props (.*);

// ==== dv/adxl_tb.sv ====
/* ADXL355 capture testbench with clock, reset and two sensor MISO models
   host register and tag stimulus, buffer readback checks and timeout */
`timescale 1ns/1ps

module adxl_tb;

  localparam int PERIOD     = 180;  // programmed frame period in ticks
  localparam int FRAMES     = 16;   // frame slots the tests use, direct mode included
  localparam int LIMIT      = FRAMES * (PERIOD * 4 + 400);
  localparam logic [5:0] IDLE_CH  = 6'h20;
  localparam logic [5:0] PULSE_CH = 6'h21;

  logic       clk;
  logic       rst_n;
  logic       reg_wr;
  logic [1:0] reg_addr;
  logic [7:0] reg_wdata;
  logic       tag_en;
  logic [5:0] tag;
  logic       tag_pulse;
  logic       miso0;
  logic       miso1;
  logic       host_sclk;
  logic       host_mosi;
  logic       host_csn;
  logic [9:0] rd_addr;
  logic       adxl_sclk;
  logic       adxl_mosi;
  logic       adxl_csn;
  logic       direct_en;
  logic [7:0] rd_data;
  logic [9:0] frame_ptr;

  int errors = 0;
  int tests_run = 0;
  int tests_failed = 0;
  int test_err0;
  int cycles = 0;
  int bit_i = 0;   // MISO bit position in the frame
  logic [5:0] tags [$];

  adxl_top u_adxl_top (.*);

  always #4 clk = ~clk;

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= LIMIT)
    begin
      $display("timeout: run did not finish within %0d cycles", LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  // data byte n is 8'h10*n plus 8'h80 on sensor 1, zero in the cmd slot
  function automatic logic [7:0] sensor_byte(input int s, input int n);
    if (n == 0)
      return 8'h00;
    return 8'((n * 16) + (s * 128));
  endfunction

  // bit i of a sensor's frame, MSB first within each byte
  function automatic logic sensor_bit(input int s, input int i);
    logic [7:0] b;
    b = sensor_byte(s, i / 8);
    return b[7 - (i % 8)];
  endfunction

  // both sensors shift out MSB first, advancing on the falling sclk
  always @(negedge adxl_csn)
    bit_i = 0;
  always @(negedge adxl_sclk)
  begin
    #1;
    if (!adxl_csn)
      bit_i = bit_i + 1;
  end
  assign miso0 = sensor_bit(0, bit_i);
  assign miso1 = sensor_bit(1, bit_i);

  // k-th stored byte of a sensor, positions 2,3 5,6 8,9; odd k carries a tag bit
  function automatic logic [7:0] expected_byte(input int s, input int k, input logic [5:0] t);
    logic [7:0] b;
    b = sensor_byte(s, (k / 2) * 3 + 2 + (k % 2));
    if (k % 2)
      b[0] = t[k / 2 + 3 * s];
    return b;
  endfunction

  // testbench errors plus failed bound assertions
  function automatic int error_count();
    return errors + u_adxl_top.u_spi_reader.u_props.fails;
  endfunction

  task automatic report_error(input string msg);
    $display("%s", msg);
    errors++;
  endtask

  task automatic write_reg(input logic [1:0] a, input logic [7:0] d);
    reg_wr    = 1'b1;
    reg_addr  = a;
    reg_wdata = d;
    @(posedge clk);
    #1 reg_wr = 1'b0;
  endtask

  task automatic push_tag(input logic [5:0] t);
    tag_en = 1'b1;
    tag    = t;
    @(posedge clk);
    #1 tag_en = 1'b0;
  endtask

  task automatic read_byte(input logic [9:0] a, output logic [7:0] d);
    rd_addr = a;
    @(posedge clk);
    #1 d = rd_data;
  endtask

  // whole frame plus the replay writes, which end 7 clks after csn rises
  task automatic wait_frame();
    @(negedge adxl_csn);
    @(posedge adxl_csn);
    assert (!adxl_sclk) else report_error("sclk high after csn rise");
    repeat (10) @(posedge clk);
    #1;
  endtask

  task automatic check_frame(input string name, input logic [5:0] t, input int nper);
    logic [7:0] d;
    logic [7:0] e;
    for (int s = 0; s < 2; s++)
      for (int k = 0; k < nper; k++)
      begin
        read_byte(frame_ptr + 10'(s * nper + k), d);
        e = expected_byte(s, k, t);
        assert (d == e)
        else report_error($sformatf("mismatch %s byte %0d: expected %h actual %h",
                                    name, s * nper + k, e, d));
      end
  endtask

  task automatic begin_test();
    test_err0 = error_count();
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (error_count() != test_err0)
      tests_failed++;
    $display("test %s: %0s", name, (error_count() == test_err0) ? "passed" : "failed");
  endtask

  task automatic direct_test();
    logic [9:0] ptr;
    int         n;
    @(negedge adxl_csn);
    @(posedge clk);
    #1 write_reg(2'd3, 8'h80);
    while (adxl_csn == 1'b0)
    begin
      assert (!direct_en) else report_error("direct_en rose during a frame");
      @(posedge clk);
      #1;
    end
    n = 0;
    while (!direct_en && n < 100)
    begin
      @(posedge clk);
      #1 n++;
    end
    assert (direct_en) else report_error("direct_en did not rise after the frame");
    ptr = frame_ptr;
    for (int i = 0; i < 8; i++)
    begin
      {host_csn, host_sclk, host_mosi} = 3'(i);
      #1;
      assert ({adxl_csn, adxl_sclk, adxl_mosi} == 3'(i))
      else report_error($sformatf("mismatch direct pins: expected %b actual %b", 3'(i),
                                  {adxl_csn, adxl_sclk, adxl_mosi}));
      @(posedge clk);
      #1;
    end
    {host_csn, host_sclk, host_mosi} = 3'b100;
    repeat (PERIOD * 8) @(posedge clk);
    #1;
    assert (frame_ptr == ptr)
    else report_error($sformatf("mismatch direct frame_ptr: expected %h actual %h",
                                ptr, frame_ptr));
    // next frame is short with len 7 and period 160, set while the host holds the pins
    write_reg(2'd1, 8'd7);
    write_reg(2'd2, 8'd160);
    write_reg(2'd3, 8'h00);
    n = 0;
    while (direct_en && n < 100)
    begin
      @(posedge clk);
      #1 n++;
    end
    assert (!direct_en) else report_error("direct_en did not fall after release");
  endtask

  initial
  begin
    logic [5:0] t;
    clk = 1'b0;
    rst_n = 1'b0;
    reg_wr = 1'b0;
    reg_addr = '0;
    reg_wdata = '0;
    tag_en = 1'b0;
    tag = '0;
    tag_pulse = 1'b0;
    host_sclk = 1'b0;
    host_mosi = 1'b0;
    host_csn = 1'b1;
    rd_addr = '0;
    void'($urandom(32'h883d2cf6));
    repeat (16) @(posedge clk);
    #1 rst_n = 1'b1;
    write_reg(2'd2, 8'(PERIOD));
    write_reg(2'd3, 8'(PERIOD >> 8));

    begin_test();
    assert (adxl_csn && !adxl_sclk) else report_error("pins not idle after reset");
    wait_frame();
    assert (adxl_csn && !adxl_sclk) else report_error("pins not idle between frames");
    end_test("pins_idle");

    begin_test();
    wait_frame();
    check_frame("untagged", IDLE_CH, 6);
    end_test("untagged");

    begin_test();
    for (int i = 0; i < 3; i++)
    begin
      t = 6'($urandom);
      tags.push_back(t);
      push_tag(t);
    end
    while (tags.size() > 0)
    begin
      wait_frame();
      check_frame("fifo_order", tags.pop_front(), 6);
    end
    wait_frame();
    check_frame("fifo_empty", IDLE_CH, 6);
    end_test("fifo_order");

    begin_test();
    tags.push_back(PULSE_CH);
    for (int i = 0; i < 2; i++)
    begin
      t = 6'($urandom);
      tags.push_back(t);
      push_tag(t);
    end
    tag_pulse = 1'b1;
    @(posedge clk);
    #1 tag_pulse = 1'b0;
    while (tags.size() > 0)
    begin
      wait_frame();
      check_frame("pulse", tags.pop_front(), 6);
    end
    end_test("pulse");

    begin_test();
    direct_test();
    end_test("direct");

    begin_test();
    wait_frame();
    check_frame("config", IDLE_CH, 4);
    end_test("config");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
             error_count());
    if (error_count() == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule

// ==== src/adxl_ctrl_regs.sv ====
/* host configuration registers: cmd, len, frame period, direct request
   byte writes, period assembled from two bytes */
`timescale 1ns/1ps
`include "adxl_defs.svh"

module adxl_ctrl_regs (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              reg_wr,    // one-clk write strobe
  input  logic [1:0]        reg_addr,
  input  adxl_pkg::byte_t   reg_wdata,
  output adxl_pkg::byte_t   cmd,       // SPI command byte
  output adxl_pkg::len_t    len,       // bytes per frame incl. cmd
  output adxl_pkg::period_t period,    // clk_en ticks per sync
  output logic              direct     // host pin request
);

  // register map
  localparam logic [1:0] A_CMD   = 2'd0;
  localparam logic [1:0] A_LEN   = 2'd1;
  localparam logic [1:0] A_PER_L = 2'd2;
  localparam logic [1:0] A_PER_H = 2'd3; // bit 7 is direct

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      cmd    <= `ADXL_DEF_CMD;
      len    <= `ADXL_DEF_LEN;
      period <= `ADXL_DEF_PERIOD;
      direct <= 1'b0;
    end
    else if (reg_wr)
    begin
      case (reg_addr)
        A_CMD:
          cmd <= reg_wdata;
        A_LEN:
          len <= reg_wdata[3:0]; // upper nibble ignored
        A_PER_L:
          period[7:0] <= reg_wdata;
        A_PER_H:
        begin
          period[15:8] <= {1'b0, reg_wdata[6:0]}; // 15-bit period reachable
          direct       <= reg_wdata[7];
        end
        default:
          cmd <= cmd;
      endcase
    end
  end

endmodule

// ==== src/adxl_defs.svh ====
/* width, depth and reset default macros for the ADXL355 capture path
   tag characters used by the tag FIFO */
`ifndef ADXL_DEFS_SVH
`define ADXL_DEFS_SVH

// storage sizes
`define ADXL_TAG_AW 11 // tag FIFO address bits, 2048 chars
`define ADXL_BUF_AW 10 // frame buffer address bits

// timing
`define ADXL_CLKDIV 4 // clk cycles per clk_en pulse

// config register reset values
`define ADXL_DEF_CMD    8'h23   // read XYZ data registers
`define ADXL_DEF_LEN    4'd10   // cmd byte + 9 data bytes
`define ADXL_DEF_PERIOD 16'd200 // clk_en ticks per sync

// tag characters
`define ADXL_TAG_PULSE_CHAR 6'h21 // "!" priority pulse
`define ADXL_TAG_IDLE_CHAR  6'h20 // space when FIFO empty

`endif

// ==== src/adxl_frame_buffer.sv ====
/* frame byte buffer with wrapping write pointer
   frame-start pointer and registered host read port */
`timescale 1ns/1ps
`include "adxl_defs.svh"

module adxl_frame_buffer (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                wr16,        // write one byte
  input  adxl_pkg::byte_t     wrdata,
  input  logic                frame_start, // first byte of a frame
  input  adxl_pkg::buf_addr_t rd_addr,
  output adxl_pkg::byte_t     rd_data,     // one clk after rd_addr
  output adxl_pkg::buf_addr_t frame_ptr    // address of last frame's first byte
);

  localparam int DEPTH = 2**`ADXL_BUF_AW;

  adxl_pkg::byte_t     mem [DEPTH];
  adxl_pkg::buf_addr_t wptr;

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wptr      <= '0;
      frame_ptr <= '0;
    end
    else if (wr16)
    begin
      wptr <= wptr + 1'b1; // wraps at DEPTH
      if (frame_start)
        frame_ptr <= wptr;
    end
  end

  always_ff @(posedge clk)
  begin
    if (wr16)
      mem[wptr] <= wrdata;
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== src/adxl_pkg.sv ====
/* shared typedefs for the ADXL355 capture path
   and the sequencer state enum */
`include "adxl_defs.svh"

package adxl_pkg;

  typedef logic [7:0]              byte_t;     // one SPI byte
  typedef logic [5:0]              tag_t;      // 6-bit tag char
  typedef logic [3:0]              len_t;      // frame length incl. cmd byte
  typedef logic [`ADXL_BUF_AW-1:0] buf_addr_t; // frame buffer address
  typedef logic [15:0]             period_t;   // frame period in clk_en ticks

  // frame sequencer
  typedef enum logic [1:0] {
    SEQ_IDLE   = 2'd0, // waiting for sync
    SEQ_XFER   = 2'd1, // csn low, shifting
    SEQ_REPLAY = 2'd2  // channel 1 bytes to buffer
  } seq_state_t;

endpackage

// ==== src/adxl_spi_reader.sv ====
/* ADXL355 frame sequencer with dual MISO capture and tag stamping
   channel 1 replay buffer, direct-mode pin mux */
`timescale 1ns/1ps

module adxl_spi_reader (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            clk_en,    // one-clk tick, half an sclk period
  input  logic            sync,      // frame request
  input  adxl_pkg::byte_t cmd,
  input  adxl_pkg::len_t  len,
  input  logic            direct,    // host asks for the pins
  input  adxl_pkg::tag_t  tag_data,
  input  logic            miso0,
  input  logic            miso1,
  input  logic            host_sclk,
  input  logic            host_mosi,
  input  logic            host_csn,
  output logic            tag_req,   // one clk at frame start
  output logic            direct_en, // pins granted to host
  output logic            adxl_sclk,
  output logic            adxl_mosi,
  output logic            adxl_csn,
  output adxl_pkg::byte_t wrdata,
  output logic            wr16,
  output logic            frame_start
);

  adxl_pkg::seq_state_t state;
  logic [7:0]           idx;       // clk_en ticks since start
  logic [7:0]           idx_end;   // len*16+4
  adxl_pkg::byte_t      cmd_q;
  adxl_pkg::len_t       len_q;
  logic                 start;
  logic                 tick;      // clk_en inside transfer
  logic                 sclk_en;
  logic                 csn_q;
  logic                 sclk_q;
  adxl_pkg::byte_t      mosi_sr;
  adxl_pkg::byte_t      sh0;
  adxl_pkg::byte_t      sh1;
  adxl_pkg::byte_t      cap0;      // shift value incl. current bit
  adxl_pkg::byte_t      cap1;
  adxl_pkg::byte_t      stamp0;
  adxl_pkg::byte_t      stamp1;
  logic                 byte_done;
  logic                 keep;      // byte position is stored
  logic                 store;
  logic                 rep_wr;
  logic                 tflag;     // this stored byte carries a tag bit
  logic [1:0]           tbit;      // tag bit index, channel 0
  logic [2:0]           tbit1;     // tag bit index, channel 1
  logic                 first_wr;
  adxl_pkg::byte_t      rep_buf [6]; // channel 1 bytes held until csn rises
  logic [2:0]           rep_wi;
  logic [2:0]           rep_ri;

  assign idx_end   = {len_q, 4'h4};
  assign start     = (state == adxl_pkg::SEQ_IDLE) && sync && !direct_en;
  assign tick      = (state == adxl_pkg::SEQ_XFER) && clk_en;
  assign cap0      = {sh0[6:0], miso0};
  assign cap1      = {sh1[6:0], miso1};
  assign byte_done = tick && sclk_en && (idx[3:0] == 4'h1); // 8th rising phase of a byte
  assign store     = byte_done && keep;
  assign rep_wr    = (state == adxl_pkg::SEQ_REPLAY) && (rep_ri != rep_wi);
  assign tbit1     = {1'b0, tbit} + 3'd3;
  assign stamp0    = tflag ? {cap0[7:1], tag_data[tbit]} : cap0;
  assign stamp1    = tflag ? {cap1[7:1], tag_data[tbit1]} : cap1;

  // idx[7:4]-1 is the byte number, keep 2,3 5,6 8,9
  always_comb
  begin
    case (idx[7:4])
      4'd3, 4'd4, 4'd6, 4'd7, 4'd9, 4'd10: keep = 1'b1;
      default:                            keep = 1'b0;
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      state     <= adxl_pkg::SEQ_IDLE;
      idx       <= '0;
      tag_req   <= 1'b0;
      direct_en <= 1'b0;
      csn_q     <= 1'b1;
      sclk_en   <= 1'b0;
      sclk_q    <= 1'b0;
      rep_ri    <= '0;
    end
    else
    begin
      tag_req <= start;
      case (state)
        adxl_pkg::SEQ_IDLE:
        begin
          if (start)
          begin
            state <= adxl_pkg::SEQ_XFER;
            idx   <= '0;
          end
          else if (clk_en)
            direct_en <= direct; // grant moves only while idle
        end
        adxl_pkg::SEQ_XFER:
        begin
          if (clk_en)
          begin
            idx <= idx + 8'd1;
            if (idx == idx_end - 8'd1) // csn rises on this tick
            begin
              state  <= adxl_pkg::SEQ_REPLAY;
              rep_ri <= '0;
            end
          end
        end
        adxl_pkg::SEQ_REPLAY:
        begin
          if (rep_ri == rep_wi)
            state <= adxl_pkg::SEQ_IDLE;
          else
            rep_ri <= rep_ri + 3'd1;
        end
        default: state <= adxl_pkg::SEQ_IDLE;
      endcase
      if (tick)
      begin
        if (idx == 8'd0)
          csn_q <= 1'b0;
        else if (idx == idx_end - 8'd1)
          csn_q <= 1'b1;
        if (idx == 8'd1)
          sclk_en <= 1'b1;
        else if (idx == idx_end - 8'd3) // after len*8 rising edges
          sclk_en <= 1'b0;
        sclk_q <= sclk_en & idx[0]; // high on odd ticks
      end
    end
  end

  // mosi changes on falling phase, cmd loaded ahead of first rise
  always_ff @(posedge clk)
  begin
    if (!rst_n)
      mosi_sr <= '0;
    else if (tick && !idx[0])
      mosi_sr <= (idx == 8'd2) ? cmd_q : {mosi_sr[6:0], 1'b0};
  end

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      tflag    <= 1'b0;
      tbit     <= '0;
      rep_wi   <= '0;
      first_wr <= 1'b0;
      wr16        <= 1'b0;
      frame_start <= 1'b0;
    end
    else
    begin
      wr16        <= store || rep_wr;
      frame_start <= store && first_wr;
      if (start)
      begin
        tflag    <= 1'b0;
        tbit     <= '0;
        rep_wi   <= '0;
        first_wr <= 1'b1;
      end
      else if (store)
      begin
        tflag    <= ~tflag;
        tbit     <= tflag ? tbit + 2'd1 : tbit;
        rep_wi   <= rep_wi + 3'd1;
        first_wr <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      cmd_q <= cmd;
      len_q <= len;
    end
    if (tick && sclk_en && idx[0]) // sample on rising phase
    begin
      sh0 <= cap0;
      sh1 <= cap1;
    end
    if (store)
      rep_buf[rep_wi] <= stamp1;
    if (rep_wr)
      wrdata <= rep_buf[rep_ri];
    else if (store)
      wrdata <= stamp0; // channel 0 straight out
  end

  // host passthrough
  assign adxl_csn  = direct_en ? host_csn  : csn_q;
  assign adxl_sclk = direct_en ? host_sclk : sclk_q;
  assign adxl_mosi = direct_en ? host_mosi : mosi_sr[7];

endmodule

// ==== src/adxl_tag_fifo.sv ====
/* tag character FIFO with pending pulse-tag latch
   hands one char per frame, idle char when empty */
`timescale 1ns/1ps
`include "adxl_defs.svh"

module adxl_tag_fifo (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          tag_en,    // push one char
  input  adxl_pkg::tag_t tag,
  input  logic          tag_pulse, // request "!" at next frame
  input  logic          tag_req,   // frame start, latch next char
  output adxl_pkg::tag_t tag_data
);

  localparam int DEPTH = 2**`ADXL_TAG_AW;

  adxl_pkg::tag_t          mem [DEPTH];
  logic [`ADXL_TAG_AW-1:0] wptr;
  logic [`ADXL_TAG_AW-1:0] rptr;
  logic                    pend;  // pulse char waiting
  logic                    empty;
  logic                    full;
  logic                    pop;

  assign empty = (wptr == rptr);
  assign full  = ((wptr + 1'b1) == rptr);
  assign pop   = tag_req && !pend && !empty; // head only used without pending pulse

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wptr <= '0;
      rptr <= '0;
      pend <= 1'b0;
    end
    else
    begin
      if (tag_en)
        wptr <= wptr + 1'b1;
      if (pop || (tag_en && full)) // pop, or drop oldest on overflow
        rptr <= rptr + 1'b1;
      if (tag_pulse)
        pend <= 1'b1;
      else if (tag_req)
        pend <= 1'b0; // consumed by this frame
    end
  end

  always_ff @(posedge clk)
  begin
    if (tag_en)
      mem[wptr] <= tag;
    if (tag_req)
      tag_data <= pend ? `ADXL_TAG_PULSE_CHAR :
                  !empty ? mem[rptr] : `ADXL_TAG_IDLE_CHAR;
  end

endmodule

// ==== src/adxl_timebase.sv ====
/* clk_en divider and frame sync timer
   new period applied at the next wrap */
`timescale 1ns/1ps
`include "adxl_defs.svh"

module adxl_timebase (
  input  logic              clk,
  input  logic              rst_n,
  input  adxl_pkg::period_t period,
  output logic              clk_en, // one clk every ADXL_CLKDIV
  output logic              sync    // one clk, with clk_en, every period ticks
);

  localparam int DIV_W = $clog2(`ADXL_CLKDIV);

  logic [DIV_W-1:0]  div;
  adxl_pkg::period_t tick_cnt;
  adxl_pkg::period_t period_q; // active period
  logic              div_wrap;
  logic              tick_wrap;

  assign div_wrap  = (div == DIV_W'(`ADXL_CLKDIV - 1));
  assign tick_wrap = (tick_cnt >= period_q - 16'd1);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      div      <= '0;
      clk_en   <= 1'b0;
      sync     <= 1'b0;
      tick_cnt <= '0;
      period_q <= `ADXL_DEF_PERIOD;
    end
    else
    begin
      clk_en <= div_wrap;
      sync   <= div_wrap && tick_wrap; // lands on a clk_en cycle
      div    <= div_wrap ? '0 : div + 1'b1;
      if (div_wrap)
      begin
        if (tick_wrap)
        begin
          tick_cnt <= '0;
          period_q <= period; // pick up host change
        end
        else
          tick_cnt <= tick_cnt + 16'd1;
      end
    end
  end

endmodule

// ==== src/adxl_top.sv ====
/* ADXL355 dual-sensor capture top
   config regs, timebase, tag FIFO, sequencer and frame buffer */
`timescale 1ns/1ps

module adxl_top (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                reg_wr,
  input  logic [1:0]          reg_addr,
  input  adxl_pkg::byte_t     reg_wdata,
  input  logic                tag_en,
  input  adxl_pkg::tag_t      tag,
  input  logic                tag_pulse,
  input  logic                miso0,
  input  logic                miso1,
  input  logic                host_sclk,
  input  logic                host_mosi,
  input  logic                host_csn,
  input  adxl_pkg::buf_addr_t rd_addr,
  output logic                adxl_sclk,
  output logic                adxl_mosi,
  output logic                adxl_csn,
  output logic                direct_en,
  output adxl_pkg::byte_t     rd_data,
  output adxl_pkg::buf_addr_t frame_ptr
);

  adxl_pkg::byte_t   cmd;
  adxl_pkg::len_t    len;
  adxl_pkg::period_t period;
  logic              direct;
  logic              clk_en;
  logic              sync;
  logic              tag_req;
  adxl_pkg::tag_t    tag_data;
  adxl_pkg::byte_t   wrdata;
  logic              wr16;
  logic              frame_start;

  adxl_ctrl_regs u_ctrl_regs (
    .clk, .rst_n, .reg_wr, .reg_addr, .reg_wdata,
    .cmd, .len, .period, .direct
  );

  adxl_timebase u_timebase (
    .clk, .rst_n, .period, .clk_en, .sync
  );

  adxl_tag_fifo u_tag_fifo (
    .clk, .rst_n, .tag_en, .tag, .tag_pulse, .tag_req, .tag_data
  );

  adxl_spi_reader u_spi_reader (
    .clk, .rst_n, .clk_en, .sync, .cmd, .len, .direct, .tag_data,
    .miso0, .miso1, .host_sclk, .host_mosi, .host_csn,
    .tag_req, .direct_en, .adxl_sclk, .adxl_mosi, .adxl_csn,
    .wrdata, .wr16, .frame_start
  );

  adxl_frame_buffer u_frame_buffer (
    .clk, .rst_n, .wr16, .wrdata, .frame_start, .rd_addr, .rd_data, .frame_ptr
  );

endmodule

// ==== vlog.f ====
+incdir+src
src/adxl_pkg.sv
src/adxl_tag_fifo.sv
src/adxl_spi_reader.sv
src/adxl_ctrl_regs.sv
src/adxl_timebase.sv
src/adxl_frame_buffer.sv
src/adxl_top.sv
dv/adxl_props.sv
dv/adxl_tb.sv
